// ==== Makefile ====
# Build with Verilator, run, and search the log for the pass line

sim:
	verilator --binary --timing --assert -f forwardUnit.f --top-module forwardUnitTb -o simv
	./obj_dir/simv | tee sim.log
	grep -q "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== dv/forwardUnitTb.sv ====
`include "forwardUnit_defs.svh"

module forwardUnitTb
    import forwardPkg::*;
();

    localparam int MAX_ROWS      = 16;
    localparam int RESET_TIMEOUT = 20;

    // One table row of producer stages, ID/EXE and ID inputs and expected responses
    typedef struct packed {
        logic [`REG_ADDR_W-1:0] exeMemReg, memWbReg, wbReg;
        logic [`DATA_W-1:0]     exeMemValue, memReadData, memWbValue, wbValue;
        logic                   exeMemWrite, exeMemLoad, memWbWrite, wbWrite;
        logic                   exeValid, exeJump, exeImmediate;
        logic [`REG_ADDR_W-1:0] rsNum, rtNum;
        logic [`DATA_W-1:0]     operandAIn, operandBIn;
        logic                   decodeValid;
        instrWord_u             decodeInstr;
        logic [`DATA_W-1:0]     branchRegA, branchRegB, jumpRegValue;
        logic [`REG_ADDR_W-1:0] idExeReg;
        logic                   idExeWrite;
        logic [`DATA_W-1:0]     expOperandA, expOperandB;
        logic                   expAluForward;
        logic [`DATA_W-1:0]     expBranchA, expBranchB, expJumpTarget;
        logic                   expBranchForward, expJumpForward, expDecodeReady;
    } row_t;

    logic CLOCK;
    logic RESET;
    row_t cur;

    logic [`DATA_W-1:0] operandAOut, operandBOut;
    logic               aluForward;
    logic [`DATA_W-1:0] branchOperandA, branchOperandB, jumpTarget;
    logic               branchForward, jumpForward, decodeReady;

    row_t        rows [MAX_ROWS];
    string       rowName [MAX_ROWS];
    int          rowCount;
    int          errorCount;
    int          rowErrors;
    logic [31:0] rngState;

    forwardUnit u_dut (
        .CLOCK          (CLOCK),
        .RESET          (RESET),
        .exeMemReg      (cur.exeMemReg),
        .exeMemValue    (cur.exeMemValue),
        .exeMemWrite    (cur.exeMemWrite),
        .exeMemLoad     (cur.exeMemLoad),
        .memReadData    (cur.memReadData),
        .memWbReg       (cur.memWbReg),
        .memWbValue     (cur.memWbValue),
        .memWbWrite     (cur.memWbWrite),
        .wbReg          (cur.wbReg),
        .wbValue        (cur.wbValue),
        .wbWrite        (cur.wbWrite),
        .exeValid       (cur.exeValid),
        .exeJump        (cur.exeJump),
        .exeImmediate   (cur.exeImmediate),
        .rsNum          (cur.rsNum),
        .rtNum          (cur.rtNum),
        .operandAIn     (cur.operandAIn),
        .operandBIn     (cur.operandBIn),
        .decodeValid    (cur.decodeValid),
        .decodeInstr    (cur.decodeInstr),
        .branchRegA     (cur.branchRegA),
        .branchRegB     (cur.branchRegB),
        .jumpRegValue   (cur.jumpRegValue),
        .idExeReg       (cur.idExeReg),
        .idExeWrite     (cur.idExeWrite),
        .operandAOut    (operandAOut),
        .operandBOut    (operandBOut),
        .aluForward     (aluForward),
        .branchOperandA (branchOperandA),
        .branchOperandB (branchOperandB),
        .jumpTarget     (jumpTarget),
        .branchForward  (branchForward),
        .jumpForward    (jumpForward),
        .decodeReady    (decodeReady)
    );

    initial begin
        CLOCK = 1'b0;
        forever #20 CLOCK = ~CLOCK;
    end

    // Released on a falling edge after five rising edges
    initial begin
        RESET = 1'b0;
        repeat (5) @(posedge CLOCK);
        @(negedge CLOCK);
        RESET = 1'b1;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function logic [`DATA_W-1:0] drawWord();
        rngState = xorshift32(rngState);
        return rngState;
    endfunction

    function automatic instrWord_u branchWord(input logic [5:0] opcode,
                                              input logic [`REG_ADDR_W-1:0] rs,
                                              input logic [`REG_ADDR_W-1:0] rt);
        instrWord_u w;
        w.iFormat.opcode    = opcode;
        w.iFormat.rs        = rs;
        w.iFormat.rt        = rt;
        w.iFormat.immediate = 16'h0010;
        return w;
    endfunction

    function automatic instrWord_u specialWord(input logic [`REG_ADDR_W-1:0] rs,
                                               input logic [5:0] funct);
        instrWord_u w;
        w.rFormat.opcode = `OPC_SPECIAL;
        w.rFormat.rs     = rs;
        w.rFormat.rt     = 5'd0;
        w.rFormat.rd     = 5'd3;
        w.rFormat.shamt  = 5'd0;
        w.rFormat.funct  = funct;
        return w;
    endfunction

    // Random data and no register match so every output passes its input through
    function automatic row_t defaultRow();
        row_t r;
        r = '0;
        r.exeMemValue    = drawWord();
        r.memReadData    = drawWord();
        r.memWbValue     = drawWord();
        r.wbValue        = drawWord();
        r.operandAIn     = drawWord();
        r.operandBIn     = drawWord();
        r.branchRegA     = drawWord();
        r.branchRegB     = drawWord();
        r.jumpRegValue   = drawWord();
        r.exeValid       = 1'b1;
        r.expOperandA    = r.operandAIn;
        r.expOperandB    = r.operandBIn;
        r.expBranchA     = r.branchRegA;
        r.expBranchB     = r.branchRegB;
        r.expJumpTarget  = r.jumpRegValue;
        r.expDecodeReady = 1'b1;
        return r;
    endfunction

    function automatic row_t allProducers(input row_t r, input logic [`REG_ADDR_W-1:0] regNum);
        row_t o;
        o             = r;
        o.exeMemReg   = regNum;
        o.memWbReg    = regNum;
        o.wbReg       = regNum;
        o.exeMemWrite = 1'b1;
        o.memWbWrite  = 1'b1;
        o.wbWrite     = 1'b1;
        return o;
    endfunction

    task automatic addRow(input string name, input row_t r);
        rows[rowCount]    = r;
        rowName[rowCount] = name;
        rowCount++;
    endtask

    task automatic buildTable();
        row_t r;
        row_t previous;
        rowCount = 0;
        // EXE/MEM wins over the older stages
        r = allProducers(defaultRow(), 5'd5);
        r.rsNum         = 5'd5;
        r.expOperandA   = r.exeMemValue;
        r.expAluForward = 1'b1;
        addRow("exeMemPriority", r);
        r = allProducers(defaultRow(), 5'd5);
        r.rsNum         = 5'd5;
        r.exeMemLoad    = 1'b1;
        r.expOperandA   = r.memReadData;
        r.expAluForward = 1'b1;
        addRow("loadPriority", r);
        // $zero written by every stage still reads the register file
        addRow("registerZero", allProducers(defaultRow(), 5'd0));
        // rs hits a stage whose write enable is off
        r = defaultRow();
        r.rsNum         = 5'd11;
        r.exeMemReg     = 5'd11;
        r.rtNum         = 5'd6;
        r.memWbReg      = 5'd6;
        r.memWbWrite    = 1'b1;
        r.wbReg         = 5'd6;
        r.wbWrite       = 1'b1;
        r.expOperandB   = r.memWbValue;
        r.expAluForward = 1'b1;
        addRow("memWbOnRt", r);
        r = defaultRow();
        r.rtNum        = 5'd6;
        r.exeMemReg    = 5'd6;
        r.exeMemWrite  = 1'b1;
        r.exeImmediate = 1'b1;
        addRow("immediateKeepsB", r);
        r = allProducers(defaultRow(), 5'd7);
        r.rsNum   = 5'd7;
        r.rtNum   = 5'd7;
        r.exeJump = 1'b1;
        addRow("jumpNoForward", r);
        previous = r;
        // Bubble keeps the previous operands
        r = allProducers(defaultRow(), 5'd8);
        r.rsNum       = 5'd8;
        r.exeValid    = 1'b0;
        r.expOperandA = previous.expOperandA;
        r.expOperandB = previous.expOperandB;
        addRow("bubbleHolds", r);
        r = defaultRow();
        r.decodeValid      = 1'b1;
        r.decodeInstr      = branchWord(`OPC_BEQ, 5'd12, 5'd13);
        r.memWbReg         = 5'd12;
        r.memWbWrite       = 1'b1;
        r.wbReg            = 5'd13;
        r.wbWrite          = 1'b1;
        r.expBranchA       = r.memWbValue;
        r.expBranchB       = r.wbValue;
        r.expJumpTarget    = r.memWbValue;
        r.expBranchForward = 1'b1;
        addRow("beqForward", r);
        r = defaultRow();
        r.decodeValid    = 1'b1;
        r.decodeInstr    = specialWord(5'd14, `FUNCT_JR);
        r.exeMemReg      = 5'd14;
        r.exeMemWrite    = 1'b1;
        r.expBranchA     = r.exeMemValue;
        r.expJumpTarget  = r.exeMemValue;
        r.expJumpForward = 1'b1;
        addRow("jrForward", r);
        // rt still being produced in ID/EXE
        r = defaultRow();
        r.decodeValid    = 1'b1;
        r.decodeInstr    = branchWord(`OPC_BNE, 5'd15, 5'd16);
        r.wbReg          = 5'd15;
        r.wbWrite        = 1'b1;
        r.idExeReg       = 5'd16;
        r.idExeWrite     = 1'b1;
        r.expBranchA     = r.wbValue;
        r.expJumpTarget  = r.wbValue;
        r.expDecodeReady = 1'b0;
        addRow("bneStall", r);
        r = defaultRow();
        r.decodeValid    = 1'b1;
        r.decodeInstr    = specialWord(5'd17, `FUNCT_JR);
        r.exeMemReg      = 5'd17;
        r.exeMemWrite    = 1'b1;
        r.idExeReg       = 5'd17;
        r.idExeWrite     = 1'b1;
        r.expBranchA     = r.exeMemValue;
        r.expJumpTarget  = r.exeMemValue;
        r.expDecodeReady = 1'b0;
        addRow("jrStall", r);
        r = defaultRow();
        r.decodeValid = 1'b1;
        r.decodeInstr = branchWord(`OPC_BNE, 5'd18, 5'd19);
        r.idExeReg    = 5'd18;
        addRow("stallWriteOff", r);
        // ADD reading the ID/EXE destination does not stall
        r = defaultRow();
        r.decodeValid = 1'b1;
        r.decodeInstr = specialWord(5'd19, 6'd32);
        r.idExeReg    = 5'd19;
        r.idExeWrite  = 1'b1;
        addRow("nonBranchWord", r);
        r = defaultRow();
        r.decodeInstr   = branchWord(`OPC_BEQ, 5'd20, 5'd21);
        r.idExeReg      = 5'd20;
        r.idExeWrite    = 1'b1;
        r.memWbReg      = 5'd20;
        r.memWbWrite    = 1'b1;
        r.expBranchA    = r.memWbValue;
        r.expJumpTarget = r.memWbValue;
        addRow("decodeIdle", r);
    endtask

    task automatic checkWord(input string signal, input logic [`DATA_W-1:0] expected,
                             input logic [`DATA_W-1:0] actual);
        if (actual !== expected) begin
            $display("Mismatch at %0t: %s expected %h, got %h", $time, signal, expected, actual);
            errorCount++;
            rowErrors++;
        end
    endtask

    task automatic checkFlag(input string signal, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Mismatch at %0t: %s expected %b, got %b", $time, signal, expected, actual);
            errorCount++;
            rowErrors++;
        end
    endtask

    task automatic checkDecode(input row_t r);
        checkWord("branchOperandA", r.expBranchA, branchOperandA);
        checkWord("branchOperandB", r.expBranchB, branchOperandB);
        checkWord("jumpTarget", r.expJumpTarget, jumpTarget);
        checkFlag("branchForward", r.expBranchForward, branchForward);
        checkFlag("jumpForward", r.expJumpForward, jumpForward);
        checkFlag("decodeReady", r.expDecodeReady, decodeReady);
    endtask

    task automatic checkExecute(input row_t r);
        checkWord("operandAOut", r.expOperandA, operandAOut);
        checkWord("operandBOut", r.expOperandB, operandBOut);
        checkFlag("aluForward", r.expAluForward, aluForward);
    endtask

    initial begin
        int waitCycles;
        int assertFailures;
        cur        = '0;
        rngState   = 32'h3e60_1597;
        errorCount = 0;
        buildTable();
        waitCycles = 0;
        while (RESET !== 1'b1 && waitCycles < RESET_TIMEOUT) begin
            @(posedge CLOCK);
            waitCycles++;
        end
        if (RESET !== 1'b1) begin
            $display("Timeout: RESET was not released within %0d cycles", RESET_TIMEOUT);
            $display("TESTS FAILED");
            $finish;
        end else begin
            @(negedge CLOCK);
            rowErrors = 0;
            checkWord("operandAOut", '0, operandAOut);
            checkWord("operandBOut", '0, operandBOut);
            checkFlag("aluForward", 1'b0, aluForward);
            $display("Row reset: %s", (rowErrors == 0) ? "ok" : "errors");
            for (int i = 0; i < rowCount; i++) begin
                rowErrors = 0;
                cur       = rows[i];
                // Decode side settles well before the rising edge
                #10;
                checkDecode(rows[i]);
                @(negedge CLOCK);
                checkExecute(rows[i]);
                $display("Row %0d %s: %s", i, rowName[i], (rowErrors == 0) ? "ok" : "errors");
            end
            assertFailures = u_dut.fwdChk.assertFailures;
            $display("Summary: %0d rows plus reset, %0d errors, %0d assertion failures",
                     rowCount, errorCount, assertFailures);
            if (errorCount == 0 && assertFailures == 0) begin
                $display("TESTS PASSED");
            end else begin
                $display("TESTS FAILED");
            end
            $finish;
        end
    end

endmodule

// ==== dv/forwardUnit_chk.sv ====
module forwardUnitChk (
    input logic CLOCK,
    input logic RESET,
    input logic decodeValid,
    input logic decodeReady,
    input logic branchForward,
    input logic jumpForward,
    input logic aluForward
);

    int assertFailures = 0;

    // A stalled ID never reports a forward
    stallQuietsFlags: assert property (@(posedge CLOCK)
        !decodeReady |-> (!branchForward && !jumpForward))
        else begin
            assertFailures++;
            $error("branchForward or jumpForward high while decodeReady is low");
        end

    // Nothing to stall on without an instruction in ID
    idleIsReady: assert property (@(posedge CLOCK)
        !decodeValid |-> decodeReady)
        else begin
            assertFailures++;
            $error("decodeReady low while decodeValid is low");
        end

    resetClearsForward: assert property (@(posedge CLOCK)
        !RESET |=> !aluForward)
        else begin
            assertFailures++;
            $error("aluForward high in the cycle after a reset edge");
        end

endmodule

bind forwardUnit forwardUnitChk fwdChk (
    .CLOCK         (CLOCK),
    .RESET         (RESET),
    .decodeValid   (decodeValid),
    .decodeReady   (decodeReady),
    .branchForward (branchForward),
    .jumpForward   (jumpForward),
    .aluForward    (aluForward)
);

// ==== forwardUnit.f ====
+incdir+source
source/forwardPkg.sv
source/resultBus_if.sv
source/bypassSelect.sv
source/executeBypass.sv
source/decodeBypass.sv
source/forwardUnit.sv
dv/forwardUnit_chk.sv
dv/forwardUnitTb.sv

// ==== source/bypassSelect.sv ====
`include "forwardUnit_defs.svh"

module bypassSelect (
    input  logic [`REG_ADDR_W-1:0] regNum,
    resultBus_if.sink              bus,
    output logic                   hit,
    output logic [`DATA_W-1:0]     value
);

    logic exeMemMatch;
    logic memWbMatch;
    logic wbMatch;

    // A stage matches only when it actually writes that register
    assign exeMemMatch = bus.exeMemWrite && (bus.exeMemReg == regNum);
    assign memWbMatch  = bus.memWbWrite && (bus.memWbReg == regNum);
    assign wbMatch     = bus.wbWrite && (bus.wbReg == regNum);

    always_comb begin
        hit   = 1'b0;
        value = '0;
        // $zero is hardwired and never forwarded
        if (regNum != '0) begin
            if (exeMemMatch) begin
                hit = 1'b1;
                // Load in EXE/MEM has its result on the memory read port
                if (bus.exeMemLoad) begin
                    value = bus.memReadData;
                end else begin
                    value = bus.exeMemValue;
                end
            end else if (memWbMatch) begin
                hit   = 1'b1;
                value = bus.memWbValue;
            end else if (wbMatch) begin
                hit   = 1'b1;
                value = bus.wbValue;
            end
        end
    end

endmodule

// ==== source/decodeBypass.sv ====
`include "forwardUnit_defs.svh"

module decodeBypass
    import forwardPkg::*;
(
    resultBus_if.sink              bus,
    input  logic                   decodeValid,
    input  instrWord_u             decodeInstr,
    input  logic [`DATA_W-1:0]     branchRegA,
    input  logic [`DATA_W-1:0]     branchRegB,
    input  logic [`DATA_W-1:0]     jumpRegValue,
    input  logic [`REG_ADDR_W-1:0] idExeReg,
    input  logic                   idExeWrite,
    output logic [`DATA_W-1:0]     branchOperandA,
    output logic [`DATA_W-1:0]     branchOperandB,
    output logic [`DATA_W-1:0]     jumpTarget,
    output logic                   branchForward,
    output logic                   jumpForward,
    output logic                   decodeReady
);

    logic [`REG_ADDR_W-1:0] rsNum;
    logic [`REG_ADDR_W-1:0] rtNum;
    logic                   isBranch;
    logic                   isJr;
    logic                   idExeLive;
    logic                   rsPending;
    logic                   rtPending;
    logic                   hazard;
    logic                   rsHit;
    logic                   rtHit;
    logic [`DATA_W-1:0]     rsValue;
    logic [`DATA_W-1:0]     rtValue;

    // rs and rt sit at the same bits in both formats
    assign rsNum = decodeInstr.iFormat.rs;
    assign rtNum = decodeInstr.iFormat.rt;

    assign isBranch = decodeValid &&
                      ((decodeInstr.iFormat.opcode == `OPC_BEQ) ||
                       (decodeInstr.iFormat.opcode == `OPC_BNE));
    assign isJr     = decodeValid &&
                      (decodeInstr.rFormat.opcode == `OPC_SPECIAL) &&
                      (decodeInstr.rFormat.funct == `FUNCT_JR);

    // Result of the ID/EXE instruction is not available yet
    assign idExeLive = idExeWrite && (idExeReg != '0);
    assign rsPending = idExeLive && (rsNum == idExeReg);
    assign rtPending = idExeLive && (rtNum == idExeReg);

    // Branch needs both comparands and JR only rs
    assign hazard      = (isBranch && (rsPending || rtPending)) || (isJr && rsPending);
    assign decodeReady = !hazard;

    bypassSelect rsSelect (
        .regNum (rsNum),
        .bus    (bus),
        .hit    (rsHit),
        .value  (rsValue)
    );

    bypassSelect rtSelect (
        .regNum (rtNum),
        .bus    (bus),
        .hit    (rtHit),
        .value  (rtValue)
    );

    // Fall back on the register file read when nothing newer exists
    assign branchOperandA = rsHit ? rsValue : branchRegA;
    assign branchOperandB = rtHit ? rtValue : branchRegB;
    assign jumpTarget     = rsHit ? rsValue : jumpRegValue;

    // Flags stay low while ID is stalled
    assign branchForward = isBranch && !hazard && (rsHit || rtHit);
    assign jumpForward   = isJr && !hazard && rsHit;

endmodule

// ==== source/executeBypass.sv ====
`include "forwardUnit_defs.svh"

module executeBypass (
    input  logic                   CLOCK,
    input  logic                   RESET,
    resultBus_if.sink              bus,
    input  logic                   exeValid,
    input  logic                   exeJump,
    input  logic                   exeImmediate,
    input  logic [`REG_ADDR_W-1:0] rsNum,
    input  logic [`REG_ADDR_W-1:0] rtNum,
    input  logic [`DATA_W-1:0]     operandAIn,
    input  logic [`DATA_W-1:0]     operandBIn,
    output logic [`DATA_W-1:0]     operandAOut,
    output logic [`DATA_W-1:0]     operandBOut,
    output logic                   aluForward
);

    logic                 rsHit;
    logic                 rtHit;
    logic [`DATA_W-1:0]   rsValue;
    logic [`DATA_W-1:0]   rtValue;
    logic                 forwardA;
    logic                 forwardB;

    bypassSelect rsSelect (
        .regNum (rsNum),
        .bus    (bus),
        .hit    (rsHit),
        .value  (rsValue)
    );

    bypassSelect rtSelect (
        .regNum (rtNum),
        .bus    (bus),
        .hit    (rtHit),
        .value  (rtValue)
    );

    // Jumps never take forwarded operands
    assign forwardA = rsHit && !exeJump;
    // Operand B carries the immediate for I-type instructions
    assign forwardB = rtHit && !exeJump && !exeImmediate;

    always_ff @(posedge CLOCK) begin
        if (!RESET) begin
            operandAOut <= '0;
            operandBOut <= '0;
            aluForward  <= 1'b0;
        end else if (exeValid) begin
            if (forwardA) begin
                operandAOut <= rsValue;
            end else begin
                operandAOut <= operandAIn;
            end
            if (forwardB) begin
                operandBOut <= rtValue;
            end else begin
                operandBOut <= operandBIn;
            end
            aluForward <= forwardA || forwardB;
        end else begin
            // Bubble holds the operands and drops the flag
            aluForward <= 1'b0;
        end
    end

endmodule

// ==== source/forwardPkg.sv ====
`include "forwardUnit_defs.svh"

package forwardPkg;

    // R-format view for picking out JR
    typedef struct packed {
        logic [5:0]             opcode;
        logic [`REG_ADDR_W-1:0] rs;
        logic [`REG_ADDR_W-1:0] rt;
        logic [`REG_ADDR_W-1:0] rd;
        logic [4:0]             shamt;
        logic [5:0]             funct;
    } rFormat_t;

    // I-format view for BEQ and BNE
    typedef struct packed {
        logic [5:0]             opcode;
        logic [`REG_ADDR_W-1:0] rs;
        logic [`REG_ADDR_W-1:0] rt;
        logic [15:0]            immediate;
    } iFormat_t;

    // One ID-stage word with two decodings
    typedef union packed {
        rFormat_t rFormat;
        iFormat_t iFormat;
    } instrWord_u;

endpackage

// ==== source/forwardUnit.sv ====
`include "forwardUnit_defs.svh"

module forwardUnit
    import forwardPkg::*;
(
    input  logic                   CLOCK,
    input  logic                   RESET,

    // EXE/MEM stage
    input  logic [`REG_ADDR_W-1:0] exeMemReg,
    input  logic [`DATA_W-1:0]     exeMemValue,
    input  logic                   exeMemWrite,
    input  logic                   exeMemLoad,
    input  logic [`DATA_W-1:0]     memReadData,

    // MEM/WB stage
    input  logic [`REG_ADDR_W-1:0] memWbReg,
    input  logic [`DATA_W-1:0]     memWbValue,
    input  logic                   memWbWrite,

    // Register file write
    input  logic [`REG_ADDR_W-1:0] wbReg,
    input  logic [`DATA_W-1:0]     wbValue,
    input  logic                   wbWrite,

    // ID/EXE instruction
    input  logic                   exeValid,
    input  logic                   exeJump,
    input  logic                   exeImmediate,
    input  logic [`REG_ADDR_W-1:0] rsNum,
    input  logic [`REG_ADDR_W-1:0] rtNum,
    input  logic [`DATA_W-1:0]     operandAIn,
    input  logic [`DATA_W-1:0]     operandBIn,

    // ID instruction
    input  logic                   decodeValid,
    input  instrWord_u             decodeInstr,
    input  logic [`DATA_W-1:0]     branchRegA,
    input  logic [`DATA_W-1:0]     branchRegB,
    input  logic [`DATA_W-1:0]     jumpRegValue,
    input  logic [`REG_ADDR_W-1:0] idExeReg,
    input  logic                   idExeWrite,

    // To EXE
    output logic [`DATA_W-1:0]     operandAOut,
    output logic [`DATA_W-1:0]     operandBOut,
    output logic                   aluForward,

    // To ID and IF
    output logic [`DATA_W-1:0]     branchOperandA,
    output logic [`DATA_W-1:0]     branchOperandB,
    output logic [`DATA_W-1:0]     jumpTarget,
    output logic                   branchForward,
    output logic                   jumpForward,
    output logic                   decodeReady
);

    resultBus_if resultBus ();

    // Producer stages onto the shared result bus
    assign resultBus.exeMemReg   = exeMemReg;
    assign resultBus.exeMemValue = exeMemValue;
    assign resultBus.exeMemWrite = exeMemWrite;
    assign resultBus.exeMemLoad  = exeMemLoad;
    assign resultBus.memReadData = memReadData;
    assign resultBus.memWbReg    = memWbReg;
    assign resultBus.memWbValue  = memWbValue;
    assign resultBus.memWbWrite  = memWbWrite;
    assign resultBus.wbReg       = wbReg;
    assign resultBus.wbValue     = wbValue;
    assign resultBus.wbWrite     = wbWrite;

    executeBypass execBypass (
        .CLOCK        (CLOCK),
        .RESET        (RESET),
        .bus          (resultBus.sink),
        .exeValid     (exeValid),
        .exeJump      (exeJump),
        .exeImmediate (exeImmediate),
        .rsNum        (rsNum),
        .rtNum        (rtNum),
        .operandAIn   (operandAIn),
        .operandBIn   (operandBIn),
        .operandAOut  (operandAOut),
        .operandBOut  (operandBOut),
        .aluForward   (aluForward)
    );

    decodeBypass decBypass (
        .bus            (resultBus.sink),
        .decodeValid    (decodeValid),
        .decodeInstr    (decodeInstr),
        .branchRegA     (branchRegA),
        .branchRegB     (branchRegB),
        .jumpRegValue   (jumpRegValue),
        .idExeReg       (idExeReg),
        .idExeWrite     (idExeWrite),
        .branchOperandA (branchOperandA),
        .branchOperandB (branchOperandB),
        .jumpTarget     (jumpTarget),
        .branchForward  (branchForward),
        .jumpForward    (jumpForward),
        .decodeReady    (decodeReady)
    );

endmodule

// ==== source/forwardUnit_defs.svh ====
`ifndef FORWARDUNIT_DEFS_SVH
`define FORWARDUNIT_DEFS_SVH

// Register number and data word widths
`define REG_ADDR_W 5
`define DATA_W 32

// Primary opcodes seen in ID
`define OPC_SPECIAL 6'd0
`define OPC_BEQ 6'd4
`define OPC_BNE 6'd5

// Function code of JR under the SPECIAL opcode
`define FUNCT_JR 6'd8

`endif

// ==== source/resultBus_if.sv ====
`include "forwardUnit_defs.svh"

interface resultBus_if;

    // EXE/MEM stage
    logic [`REG_ADDR_W-1:0] exeMemReg;
    logic [`DATA_W-1:0]     exeMemValue;
    logic                   exeMemWrite;
    logic                   exeMemLoad;
    // Load data returned by memory for the EXE/MEM instruction
    logic [`DATA_W-1:0]     memReadData;

    // MEM/WB stage
    logic [`REG_ADDR_W-1:0] memWbReg;
    logic [`DATA_W-1:0]     memWbValue;
    logic                   memWbWrite;

    // Register file write port
    logic [`REG_ADDR_W-1:0] wbReg;
    logic [`DATA_W-1:0]     wbValue;
    logic                   wbWrite;

    modport source (
        output exeMemReg, exeMemValue, exeMemWrite, exeMemLoad, memReadData,
        output memWbReg, memWbValue, memWbWrite,
        output wbReg, wbValue, wbWrite
    );

    modport sink (
        input exeMemReg, exeMemValue, exeMemWrite, exeMemLoad, memReadData,
        input memWbReg, memWbValue, memWbWrite,
        input wbReg, wbValue, wbWrite
    );

endinterface
